/* src/raster_stream_pkg.sv */
/*
 * Raster stream definitions
 * Attribute types of one fragment as produced by the rasterizer back end,
 * and the joined fragment that leaves the attribute join.
 */
package raster_stream_pkg;

    // Linear pixel position in the framebuffer
    typedef logic [15:0] pixel_index_t;

    // RGBA8888 with alpha in the top byte
    typedef logic [31:0] color_t;

    // Single alpha channel value, also used for the test reference
    typedef logic [7:0] alpha_t;

    typedef logic [15:0] depth_t;

    // Per-fragment flags byte, passed through untouched
    typedef logic [7:0] flags_t;

    // Bit position of the alpha byte inside color_t
    localparam int ALPHA_LSB = 24;

    // Joined fragment
    // The index sits in the least significant position, followed by color,
    // depth and flags, so the packed layout matches {flags, depth, color, index}
    typedef struct packed {
        flags_t       flags;
        depth_t       depth;
        color_t       color;
        pixel_index_t index;
    } fragment_t;

endpackage

/* src/stream_fifo.sv */
/*
 * Synchronous stream FIFO
 * Register array with wrap-bit pointers and a combinational read port.
 * The head entry is visible on o_data as soon as o_empty falls.
 * Writes while full and reads while empty are ignored.
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DATA_WIDTH      = 8,
    parameter int FIFO_DEPTH_POW2 = 5
) (
    input  logic                         aclk,
    input  logic                         i_rst_n,

    input  logic                         i_wr,
    input  logic [DATA_WIDTH-1:0]        i_data,
    output logic                         o_full,
    output logic                         o_empty,
    output logic [FIFO_DEPTH_POW2:0]     o_fill,

    input  logic                         i_rd,
    output logic [DATA_WIDTH-1:0]        o_data
);

    localparam int DEPTH = 1 << FIFO_DEPTH_POW2;

    logic [DATA_WIDTH-1:0]      mem [DEPTH];

    // One extra bit on each pointer tells a full FIFO from an empty one
    logic [FIFO_DEPTH_POW2:0]   wr_ptr;
    logic [FIFO_DEPTH_POW2:0]   rd_ptr;

    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    // Fill level never exceeds DEPTH, so its top bit alone marks full
    assign o_fill  = wr_ptr - rd_ptr;
    assign o_full  = o_fill[FIFO_DEPTH_POW2];
    assign o_empty = (wr_ptr == rd_ptr);

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_DEPTH_POW2-1:0]] <= i_data;
        end
    end

    // Asynchronous read of the head entry
    assign o_data = mem[rd_ptr[FIFO_DEPTH_POW2-1:0]];

endmodule

/* src/stream_concat_fifo.sv */
/*
 * Fragment attribute joiner
 * Buffers the index, color, depth and flags streams in one FIFO each and
 * presents a fragment once every FIFO holds an entry. The output is not
 * registered: downstream ready pops all four FIFOs in the same cycle.
 */
`timescale 1ns/1ps

module stream_concat_fifo #(
    parameter int FIFO_DEPTH_POW2 = 5
) (
    input  logic                            aclk,
    input  logic                            i_rst_n,

    input  logic                            i_index_tvalid,
    input  raster_stream_pkg::pixel_index_t i_index_tdata,
    output logic                            o_index_tready,

    input  logic                            i_color_tvalid,
    input  raster_stream_pkg::color_t       i_color_tdata,
    output logic                            o_color_tready,

    input  logic                            i_depth_tvalid,
    input  raster_stream_pkg::depth_t       i_depth_tdata,
    output logic                            o_depth_tready,

    input  logic                            i_flags_tvalid,
    input  raster_stream_pkg::flags_t       i_flags_tdata,
    output logic                            o_flags_tready,

    output logic                            o_frag_tvalid,
    output raster_stream_pkg::fragment_t    o_frag_tdata,
    input  logic                            i_frag_tready
);

    // Bit order is index, color, depth, flags
    logic [3:0]                         fifo_full;
    logic [3:0]                         fifo_empty;

    raster_stream_pkg::pixel_index_t    index_head;
    raster_stream_pkg::color_t          color_head;
    raster_stream_pkg::depth_t          depth_head;
    raster_stream_pkg::flags_t          flags_head;

    logic                               frag_read;

    assign o_index_tready = !fifo_full[0];
    assign o_color_tready = !fifo_full[1];
    assign o_depth_tready = !fifo_full[2];
    assign o_flags_tready = !fifo_full[3];

    // A fragment exists only when all four heads are present
    assign o_frag_tvalid = !(|fifo_empty);
    assign frag_read     = o_frag_tvalid && i_frag_tready;

    stream_fifo #(
        .DATA_WIDTH      ($bits(raster_stream_pkg::pixel_index_t)),
        .FIFO_DEPTH_POW2 (FIFO_DEPTH_POW2)
    ) u_index_fifo (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_index_tvalid),
        .i_data  (i_index_tdata),
        .o_full  (fifo_full[0]),
        .o_empty (fifo_empty[0]),
        .o_fill  (),
        .i_rd    (frag_read),
        .o_data  (index_head)
    );

    stream_fifo #(
        .DATA_WIDTH      ($bits(raster_stream_pkg::color_t)),
        .FIFO_DEPTH_POW2 (FIFO_DEPTH_POW2)
    ) u_color_fifo (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_color_tvalid),
        .i_data  (i_color_tdata),
        .o_full  (fifo_full[1]),
        .o_empty (fifo_empty[1]),
        .o_fill  (),
        .i_rd    (frag_read),
        .o_data  (color_head)
    );

    stream_fifo #(
        .DATA_WIDTH      ($bits(raster_stream_pkg::depth_t)),
        .FIFO_DEPTH_POW2 (FIFO_DEPTH_POW2)
    ) u_depth_fifo (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_depth_tvalid),
        .i_data  (i_depth_tdata),
        .o_full  (fifo_full[2]),
        .o_empty (fifo_empty[2]),
        .o_fill  (),
        .i_rd    (frag_read),
        .o_data  (depth_head)
    );

    stream_fifo #(
        .DATA_WIDTH      ($bits(raster_stream_pkg::flags_t)),
        .FIFO_DEPTH_POW2 (FIFO_DEPTH_POW2)
    ) u_flags_fifo (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_flags_tvalid),
        .i_data  (i_flags_tdata),
        .o_full  (fifo_full[3]),
        .o_empty (fifo_empty[3]),
        .o_fill  (),
        .i_rd    (frag_read),
        .o_data  (flags_head)
    );

    always_comb begin
        o_frag_tdata.index = index_head;
        o_frag_tdata.color = color_head;
        o_frag_tdata.depth = depth_head;
        o_frag_tdata.flags = flags_head;
    end

endmodule

/* src/fragment_alpha_test.sv */
/*
 * Fragment alpha test
 * Drops fragments whose alpha is below the programmable reference and
 * holds passing fragments in a valid/data register toward the
 * framebuffer writer.
 */
`timescale 1ns/1ps

module fragment_alpha_test (
    input  logic                            aclk,
    input  logic                            i_rst_n,

    input  raster_stream_pkg::alpha_t       i_alpha_ref,

    input  logic                            i_frag_tvalid,
    input  raster_stream_pkg::fragment_t    i_frag_tdata,
    output logic                            o_frag_tready,

    output logic                            o_frag_tvalid,
    output raster_stream_pkg::fragment_t    o_frag_tdata,
    input  logic                            i_frag_tready
);

    raster_stream_pkg::alpha_t  frag_alpha;
    logic                       alpha_pass;
    logic                       frag_take;

    assign frag_alpha = i_frag_tdata.color[raster_stream_pkg::ALPHA_LSB +:
                                           $bits(raster_stream_pkg::alpha_t)];

    // Equal alpha passes
    assign alpha_pass = (frag_alpha >= i_alpha_ref);

    // The register can take a new fragment when it is empty or being drained
    assign o_frag_tready = !o_frag_tvalid || i_frag_tready;

    // Failing fragments are consumed as well, they just never load
    assign frag_take = i_frag_tvalid && o_frag_tready;

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            o_frag_tvalid <= 1'b0;
        end else if (o_frag_tready) begin
            o_frag_tvalid <= i_frag_tvalid && alpha_pass;
        end
    end

    always_ff @(posedge aclk) begin
        if (frag_take && alpha_pass) begin
            o_frag_tdata <= i_frag_tdata;
        end
    end

endmodule

/* src/fragment_join_top.sv */
/*
 * Fragment attribute join top level
 * The four attribute streams meet in the FIFO joiner, and the alpha test
 * filters and registers the joined fragments.
 */
`timescale 1ns/1ps

module fragment_join_top #(
    parameter int FIFO_DEPTH_POW2 = 5
) (
    input  logic                            aclk,
    input  logic                            i_rst_n,

    input  raster_stream_pkg::alpha_t       i_alpha_ref,

    input  logic                            i_index_tvalid,
    input  raster_stream_pkg::pixel_index_t i_index_tdata,
    output logic                            o_index_tready,

    input  logic                            i_color_tvalid,
    input  raster_stream_pkg::color_t       i_color_tdata,
    output logic                            o_color_tready,

    input  logic                            i_depth_tvalid,
    input  raster_stream_pkg::depth_t       i_depth_tdata,
    output logic                            o_depth_tready,

    input  logic                            i_flags_tvalid,
    input  raster_stream_pkg::flags_t       i_flags_tdata,
    output logic                            o_flags_tready,

    output logic                            o_frag_tvalid,
    output raster_stream_pkg::fragment_t    o_frag_tdata,
    input  logic                            i_frag_tready
);

    // Joined fragment between the joiner and the alpha test
    logic                           join_tvalid;
    raster_stream_pkg::fragment_t   join_tdata;
    logic                           join_tready;

    stream_concat_fifo #(
        .FIFO_DEPTH_POW2 (FIFO_DEPTH_POW2)
    ) u_concat (
        .aclk           (aclk),
        .i_rst_n        (i_rst_n),
        .i_index_tvalid (i_index_tvalid),
        .i_index_tdata  (i_index_tdata),
        .o_index_tready (o_index_tready),
        .i_color_tvalid (i_color_tvalid),
        .i_color_tdata  (i_color_tdata),
        .o_color_tready (o_color_tready),
        .i_depth_tvalid (i_depth_tvalid),
        .i_depth_tdata  (i_depth_tdata),
        .o_depth_tready (o_depth_tready),
        .i_flags_tvalid (i_flags_tvalid),
        .i_flags_tdata  (i_flags_tdata),
        .o_flags_tready (o_flags_tready),
        .o_frag_tvalid  (join_tvalid),
        .o_frag_tdata   (join_tdata),
        .i_frag_tready  (join_tready)
    );

    fragment_alpha_test u_alpha_test (
        .aclk          (aclk),
        .i_rst_n       (i_rst_n),
        .i_alpha_ref   (i_alpha_ref),
        .i_frag_tvalid (join_tvalid),
        .i_frag_tdata  (join_tdata),
        .o_frag_tready (join_tready),
        .o_frag_tvalid (o_frag_tvalid),
        .o_frag_tdata  (o_frag_tdata),
        .i_frag_tready (i_frag_tready)
    );

endmodule

/* test/fragment_join_assertions.sv */
/*
 * Fragment join checker
 * Bound to the top level. Watches the reset state, output hold under
 * back-pressure, the alpha rule, field consistency and fragment order.
 */
`timescale 1ns/1ps

module fragment_join_assertions (
    input  logic                            aclk,
    input  logic                            i_rst_n,
    input  raster_stream_pkg::alpha_t       i_alpha_ref,
    input  logic                            i_index_tready,
    input  logic                            i_color_tready,
    input  logic                            i_depth_tready,
    input  logic                            i_flags_tready,
    input  logic                            i_join_tvalid,
    input  logic                            i_frag_tvalid,
    input  raster_stream_pkg::fragment_t    i_frag_tdata,
    input  logic                            i_frag_tready
);

    // Failure counts, read by the testbench for its closing report
    int reset_fail = 0;
    int field_fail = 0;
    int alpha_fail = 0;
    int order_fail = 0;
    int hold_fail  = 0;

    raster_stream_pkg::pixel_index_t    last_index;
    logic                               seen_output;
    logic                               field_ok;
    raster_stream_pkg::alpha_t          out_alpha;

    // Depth is the inverted index, flags the low index byte, color low bits the index twice
    assign field_ok = (i_frag_tdata.depth == ~i_frag_tdata.index)
                   && (i_frag_tdata.flags == i_frag_tdata.index[7:0])
                   && (i_frag_tdata.color[23:0] == {i_frag_tdata.index[7:0], i_frag_tdata.index});

    assign out_alpha = i_frag_tdata.color[raster_stream_pkg::ALPHA_LSB +: 8];

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            seen_output <= 1'b0;
            last_index  <= '0;
        end else if (i_frag_tvalid && i_frag_tready) begin
            seen_output <= 1'b1;
            last_index  <= i_frag_tdata.index;
        end
    end

    reset_state: assert property (@(posedge aclk)
        !i_rst_n |=> (!i_frag_tvalid && !i_join_tvalid && i_index_tready
                      && i_color_tready && i_depth_tready && i_flags_tready))
    else begin
        $error("outputs or input readies are wrong right after reset");
        reset_fail++;
    end

    field_match: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_frag_tvalid |-> field_ok)
    else begin
        $error("output fragment fields do not belong to the same fragment");
        field_fail++;
    end

    alpha_rule: assert property (@(posedge aclk) disable iff (!i_rst_n)
        i_frag_tvalid |-> (out_alpha >= i_alpha_ref))
    else begin
        $error("output fragment alpha is below the reference");
        alpha_fail++;
    end

    index_order: assert property (@(posedge aclk) disable iff (!i_rst_n)
        (i_frag_tvalid && seen_output) |-> (i_frag_tdata.index > last_index))
    else begin
        $error("output fragment index is not above the previous one");
        order_fail++;
    end

    output_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
        (i_frag_tvalid && !i_frag_tready) |=> (i_frag_tvalid && $stable(i_frag_tdata)))
    else begin
        $error("output fragment changed while stalled");
        hold_fail++;
    end

endmodule

/* test/tb_fragment_join.sv */
/*
 * Fragment join testbench
 * Feeds the four attribute streams at uneven random rates, applies random
 * back-pressure on the output and counts the fragments that pass the
 * alpha test. The bound checker does the per-fragment checks.
 */
`timescale 1ns/1ps

module tb_fragment_join;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int BURST_LEN    = 48;
    localparam int TOTAL_FRAGS  = 2 * BURST_LEN;
    localparam int CYCLE_LIMIT  = 40 * TOTAL_FRAGS + RESET_CYCLES;
    localparam int DRAIN_LIMIT  = 100;

    logic                               aclk;
    logic                               i_rst_n;
    raster_stream_pkg::alpha_t          i_alpha_ref;

    // Source valids in the order index, color, depth, flags
    logic [3:0]                         src_valid;
    logic [3:0]                         ready_vec;
    raster_stream_pkg::pixel_index_t    index_data;
    raster_stream_pkg::color_t          color_data;
    raster_stream_pkg::depth_t          depth_data;
    raster_stream_pkg::flags_t          flags_data;

    logic                               o_index_tready;
    logic                               o_color_tready;
    logic                               o_depth_tready;
    logic                               o_flags_tready;
    logic                               o_frag_tvalid;
    raster_stream_pkg::fragment_t       o_frag_tdata;
    logic                               i_frag_tready;

    logic [15:0]                        lfsr;
    int                                 frag_num [4];
    int                                 rate [4];
    raster_stream_pkg::alpha_t          alphas [TOTAL_FRAGS];
    int                                 out_count;
    int                                 count_errors;
    int                                 assert_errors;
    int                                 stall_left;
    int                                 cycle_count;

    assign ready_vec = {o_flags_tready, o_depth_tready, o_color_tready, o_index_tready};

    bind fragment_join_top fragment_join_assertions u_checks (
        .aclk           (aclk),
        .i_rst_n        (i_rst_n),
        .i_alpha_ref    (i_alpha_ref),
        .i_index_tready (o_index_tready),
        .i_color_tready (o_color_tready),
        .i_depth_tready (o_depth_tready),
        .i_flags_tready (o_flags_tready),
        .i_join_tvalid  (join_tvalid),
        .i_frag_tvalid  (o_frag_tvalid),
        .i_frag_tdata   (o_frag_tdata),
        .i_frag_tready  (i_frag_tready)
    );

    fragment_join_top #(
        .FIFO_DEPTH_POW2 (2)
    ) uut (
        .aclk           (aclk),
        .i_rst_n        (i_rst_n),
        .i_alpha_ref    (i_alpha_ref),
        .i_index_tvalid (src_valid[0]),
        .i_index_tdata  (index_data),
        .o_index_tready (o_index_tready),
        .i_color_tvalid (src_valid[1]),
        .i_color_tdata  (color_data),
        .o_color_tready (o_color_tready),
        .i_depth_tvalid (src_valid[2]),
        .i_depth_tdata  (depth_data),
        .o_depth_tready (o_depth_tready),
        .i_flags_tvalid (src_valid[3]),
        .i_flags_tdata  (flags_data),
        .o_flags_tready (o_flags_tready),
        .o_frag_tvalid  (o_frag_tvalid),
        .o_frag_tdata   (o_frag_tdata),
        .i_frag_tready  (i_frag_tready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Fibonacci LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // Puts fragment frag_num[stream] on one attribute stream
    task automatic present_beat(input int stream);
        logic [7:0]  alpha;
        logic [15:0] k;
        k = frag_num[stream][15:0];
        case (stream)
            0: index_data = k;
            1: begin
                draw_bits(8, alpha);
                alphas[frag_num[stream]] = alpha;
                color_data = {alpha, k[7:0], k};
            end
            2: depth_data = ~k;
            default: flags_data = k[7:0];
        endcase
        src_valid[stream] = 1'b1;
    endtask

    // One clock cycle: handshakes are seen at the falling edge, inputs change after the rise
    task automatic run_cycle(input int burst_end, input logic draining);
        logic [3:0] accepted;
        logic [7:0] r;
        @(negedge aclk);
        accepted = src_valid & ready_vec;
        if (o_frag_tvalid && i_frag_tready) begin
            out_count++;
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        for (int s = 0; s < 4; s++) begin
            if (accepted[s]) begin
                frag_num[s]++;
                src_valid[s] = 1'b0;
            end
            if (!src_valid[s] && frag_num[s] < burst_end) begin
                draw_bits(2, r);
                if (int'(r[1:0]) < rate[s]) begin
                    present_beat(s);
                end
            end
        end
        if (draining) begin
            i_frag_tready = 1'b1;
        end else if (stall_left > 0) begin
            i_frag_tready = 1'b0;
            stall_left--;
        end else begin
            draw_bits(4, r);
            // A zero draw starts a long stall that lets the FIFOs fill
            if (r[3:0] == 4'd0) begin
                stall_left    = 20;
                i_frag_tready = 1'b0;
            end else begin
                i_frag_tready = r[0] | r[1];
            end
        end
    endtask

    task automatic run_burst(input string name, input raster_stream_pkg::alpha_t ref_level,
                             input int first, input int last);
        int expected;
        int start_count;
        int drain_cycles;
        i_alpha_ref = ref_level;
        start_count = out_count;
        stall_left  = 30;
        while (frag_num[0] < last || frag_num[1] < last
               || frag_num[2] < last || frag_num[3] < last) begin
            run_cycle(last, 1'b0);
        end
        drain_cycles = 0;
        while ((uut.join_tvalid || o_frag_tvalid) && drain_cycles < DRAIN_LIMIT) begin
            run_cycle(last, 1'b1);
            drain_cycles++;
        end
        if (drain_cycles >= DRAIN_LIMIT) begin
            $display("%s: fragments were still in flight after %0d drain cycles",
                     name, DRAIN_LIMIT);
            count_errors++;
        end
        expected = 0;
        for (int k = first; k < last; k++) begin
            if (alphas[k] >= ref_level) begin
                expected++;
            end
        end
        if (out_count - start_count != expected) begin
            $display("error %s: expected %0d actual %0d", name, expected,
                     out_count - start_count);
            count_errors++;
        end
    endtask

    initial begin
        i_rst_n       = 1'b0;
        i_alpha_ref   = 8'h60;
        src_valid     = '0;
        index_data    = '0;
        color_data    = '0;
        depth_data    = '0;
        flags_data    = '0;
        i_frag_tready = 1'b0;
        lfsr          = 16'd55;
        out_count     = 0;
        count_errors  = 0;
        stall_left    = 0;
        rate          = '{3, 2, 4, 1};
        frag_num      = '{0, 0, 0, 0};
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;

        // The reference changes once, with the pipeline idle in between
        run_burst("burst_ref_60", 8'h60, 0, BURST_LEN);
        run_burst("burst_ref_c0", 8'hC0, BURST_LEN, TOTAL_FRAGS);
        repeat (2) @(posedge aclk);

        assert_errors = uut.u_checks.reset_fail + uut.u_checks.field_fail
                      + uut.u_checks.alpha_fail + uut.u_checks.order_fail
                      + uut.u_checks.hold_fail;
        $display("%0d fragments out, %0d count errors, %0d assertion failures",
                 out_count, count_errors, assert_errors);
        if (count_errors == 0 && assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* list.f */
src/raster_stream_pkg.sv
src/stream_fifo.sv
src/stream_concat_fifo.sv
src/fragment_alpha_test.sv
src/fragment_join_top.sv
test/fragment_join_assertions.sv
test/tb_fragment_join.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fragment join testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fragment_join \
    -Mdir "$BUILD_DIR" -o sim_fragment_join \
    -f list.f

# A raised error limit lets the run reach its closing report after an assertion failure
"./$BUILD_DIR/sim_fragment_join" +verilator+error+limit+1000 | tee "$LOG_FILE"

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
    echo "Fragment join simulation failed, see $LOG_FILE"
    exit 1
fi

echo "Fragment join simulation passed"
exit 0
